//--- bench/mmu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_checker
   import mmu_pkg::*;
(
   input wire                clk,
   input wire                rst_n,
   input wire                req,
   input wire                ack,
   input wire                mem_req,
   input wire                mem_ack,
   input wire [PA_WIDTH-1:0] mem_addr
);

   // number of assertion failures so far
   int failures = 0;

   // ack comes out of reset low
   ack_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ack)
      else
      begin
         $error("ack high when reset is released");
         failures++;
      end

   // request side, four-phase
   ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(req))
      else
      begin
         $error("ack rose without a pending req");
         failures++;
      end

   ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ack) |-> !$past(req))
      else
      begin
         $error("ack fell while req was still high");
         failures++;
      end

   // memory side, address held until the memory answers
   mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
      else
      begin
         $error("mem_req or mem_addr changed before mem_ack");
         failures++;
      end

   mem_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(mem_req) |-> $past(mem_ack))
      else
      begin
         $error("mem_req fell without mem_ack");
         failures++;
      end

endmodule

bind mmu_top mmu_checker checker_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .req      (req),
   .ack      (ack),
   .mem_req  (mem_req),
   .mem_ack  (mem_ack),
   .mem_addr (mem_addr)
);

`default_nettype wire

//--- bench/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb
   import mmu_pkg::*;
();

   localparam int TIMEOUT = 200;
   localparam logic [PPN_WIDTH-1:0] ROOT = 28'h100;
   localparam logic [PPN_WIDTH-1:0] L1_TBL = 28'h101;
   localparam logic [PPN_WIDTH-1:0] L0_TBL = 28'h102;

   logic                 clk;
   logic                 rst_n;
   logic                 active;
   logic                 clear;
   logic [PPN_WIDTH-1:0] root_ppn;
   logic                 req;
   logic [VA_WIDTH-1:0]  va;
   logic                 store;
   logic                 ack;
   logic [PA_WIDTH-1:0]  pa;
   logic                 fault;
   logic                 mem_req;
   logic [PA_WIDTH-1:0]  mem_addr;
   logic                 mem_ack;
   logic [63:0]          mem_rdata;

   // page-table memory, keyed by byte address
   logic [63:0] pt_mem [logic [PA_WIDTH-1:0]];
   integer      seed;
   int          mem_delay;
   int          mem_reads;
   logic        mem_req_q;
   int          errors;
   int          tests_run;
   int          tests_failed;

   mmu_top #(.LG_N(2)) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .active    (active),
      .clear     (clear),
      .root_ppn  (root_ppn),
      .req       (req),
      .va        (va),
      .store     (store),
      .ack       (ack),
      .pa        (pa),
      .fault     (fault),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic [63:0] read_pte(input logic [PA_WIDTH-1:0] addr);
      return pt_mem.exists(addr) ? pt_mem[addr] : 64'd0;
   endfunction

   function automatic logic [PA_WIDTH-1:0] pte_addr(input logic [PPN_WIDTH-1:0] tbl,
                                                    input logic [8:0] idx);
      return {tbl, idx, 3'b000};
   endfunction

   function automatic logic [63:0] ptr_pte(input logic [PPN_WIDTH-1:0] ppn);
      pte_u p;
      p = '0;
      p.ptr.ppn = 44'(ppn);
      p.ptr.v = 1'b1;
      return p;
   endfunction

   function automatic logic [63:0] leaf_pte(input logic [PPN_WIDTH-1:0] ppn,
                                            input logic d, input logic w, input logic r);
      pte_u p;
      p = '0;
      p.leaf.ppn = 44'(ppn);
      p.leaf.d = d;
      p.leaf.a = 1'b1;
      p.leaf.w = w;
      p.leaf.r = r;
      p.leaf.v = 1'b1;
      return p;
   endfunction

   // expected {fault, pa} from a walk of pt_mem
   function automatic logic [PA_WIDTH:0] ref_translate(input logic [VA_WIDTH-1:0] v,
                                                       input logic st, input logic act);
      pte_u                 p;
      logic [PPN_WIDTH-1:0] tbl;
      logic [PA_WIDTH-1:0]  exp_pa;
      logic                 exp_fault;
      logic                 done;
      exp_pa = {{(PA_WIDTH-VA_WIDTH){1'b0}}, v};
      exp_fault = 1'b0;
      tbl = ROOT;
      done = !act;
      for (int lvl = 2; lvl >= 0; lvl--)
      begin
         if (!done)
         begin
            p = read_pte(pte_addr(tbl, v[12 + 9 * lvl +: 9]));
            if (!p.leaf.v)
            begin
               exp_fault = 1'b1;
               done = 1'b1;
            end
            else if (p.leaf.r || p.leaf.w)
            begin
               done = 1'b1;
               if ((p.leaf.ppn & ((44'd1 << (9 * lvl)) - 44'd1)) != 44'd0)
                  exp_fault = 1'b1;
               else
                  exp_fault = st ? !(p.leaf.w && p.leaf.d) : !p.leaf.r;
               exp_pa = {p.leaf.ppn[PPN_WIDTH-1:0], 12'h000}
                        | PA_WIDTH'(v & ((39'd1 << (12 + 9 * lvl)) - 39'd1));
            end
            else if (lvl == 0)
            begin
               exp_fault = 1'b1;
               done = 1'b1;
            end
            else
               tbl = p.ptr.ppn[PPN_WIDTH-1:0];
         end
      end
      return {exp_fault, exp_pa};
   endfunction

   task automatic build_tables();
      pt_mem[pte_addr(ROOT, 9'd0)] = ptr_pte(L1_TBL);
      pt_mem[pte_addr(ROOT, 9'd1)] = leaf_pte(28'h40000, 1'b1, 1'b1, 1'b1);
      // low ppn bits set, not a legal 1G leaf
      pt_mem[pte_addr(ROOT, 9'd2)] = leaf_pte(28'h40200, 1'b1, 1'b1, 1'b1);
      pt_mem[pte_addr(L1_TBL, 9'd0)] = ptr_pte(L0_TBL);
      pt_mem[pte_addr(L1_TBL, 9'd1)] = leaf_pte(28'h400, 1'b1, 1'b1, 1'b1);
      pt_mem[pte_addr(L1_TBL, 9'd2)] = leaf_pte(28'h401, 1'b1, 1'b1, 1'b1);
      // 4K pages 0 to 7, page 6 left unmapped
      for (int i = 0; i < 8; i++)
      begin
         if (i != 6)
            pt_mem[pte_addr(L0_TBL, 9'(i))] = leaf_pte(PPN_WIDTH'(28'h5000 + i * 3),
                                                       i != 5, i != 4, 1'b1);
      end
   endtask

   // memory answers after a random number of cycles
   always @(negedge clk)
   begin
      if (mem_req && !mem_ack)
      begin
         if (mem_delay == 0)
         begin
            mem_rdata = read_pte(mem_addr);
            mem_ack = 1'b1;
         end
         else
            mem_delay = mem_delay - 1;
      end
      else if (!mem_req && mem_ack)
      begin
         mem_ack = 1'b0;
         mem_delay = {$random(seed)} % 4;
      end
   end

   // count memory reads seen at the port
   always @(posedge clk)
   begin
      if (mem_req && !mem_req_q)
         mem_reads++;
      mem_req_q <= mem_req;
   end

   task automatic run_request(input logic [VA_WIDTH-1:0] v, input logic st,
                              output logic [PA_WIDTH-1:0] got_pa, output logic got_fault,
                              output int reads);
      int start_reads;
      int n;
      start_reads = mem_reads;
      @(negedge clk);
      req = 1'b1;
      va = v;
      store = st;
      n = 0;
      while (!ack && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (!ack)
      begin
         $display("no ack within %0d cycles for va %h", TIMEOUT, v);
         errors++;
      end
      got_pa = pa;
      got_fault = fault;
      req = 1'b0;
      n = 0;
      while (ack && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (ack)
      begin
         $display("ack still high %0d cycles after req fell", TIMEOUT);
         errors++;
      end
      reads = mem_reads - start_reads;
   endtask

   // exp_reads below zero skips the memory read count
   task automatic check_translation(input string name, input logic [VA_WIDTH-1:0] v,
                                    input logic st, input int exp_reads);
      logic [PA_WIDTH:0]   exp;
      logic [PA_WIDTH-1:0] got_pa;
      logic                got_fault;
      int                  reads;
      exp = ref_translate(v, st, active);
      run_request(v, st, got_pa, got_fault, reads);
      if (got_fault !== exp[PA_WIDTH])
      begin
         $display("FAIL %s: fault = %h, expected %h", name, got_fault, exp[PA_WIDTH]);
         errors++;
      end
      if (!exp[PA_WIDTH] && got_pa !== exp[PA_WIDTH-1:0])
      begin
         $display("FAIL %s: pa = %h, expected %h", name, got_pa, exp[PA_WIDTH-1:0]);
         errors++;
      end
      if (exp_reads >= 0 && reads != exp_reads)
      begin
         $display("FAIL %s: mem_req rises = %h, expected %h", name, reads, exp_reads);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("ok     %s", name);
      else
      begin
         tests_failed++;
         $display("failed %s", name);
      end
   endtask

   initial
   begin
      int                  e;
      int                  kind;
      int                  page;
      logic [31:0]         off;
      logic [VA_WIDTH-1:0] rva;
      seed = 40;
      rst_n = 1'b0;
      active = 1'b0;
      clear = 1'b0;
      root_ppn = ROOT;
      req = 1'b0;
      va = '0;
      store = 1'b0;
      mem_ack = 1'b0;
      mem_rdata = '0;
      mem_delay = 0;
      mem_reads = 0;
      mem_req_q = 1'b0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      build_tables();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      e = errors;
      check_translation("bare load", 39'h12_3456_789a, 1'b0, 0);
      check_translation("bare store", 39'h00_0000_5010, 1'b1, 0);
      finish_test("bare mode", e);
      active = 1'b1;

      e = errors;
      check_translation("4k first", 39'h2abc, 1'b0, 3);
      check_translation("4k repeat", 39'h2abc, 1'b0, 0);
      finish_test("4k translation", e);

      e = errors;
      check_translation("2m load", 39'h21_2345, 1'b0, 2);
      check_translation("1g store", 39'h4123_4567, 1'b1, 1);
      check_translation("2m misaligned", 39'h40_0010, 1'b0, 2);
      check_translation("1g misaligned", 39'h8000_0020, 1'b0, 1);
      finish_test("superpages", e);

      e = errors;
      check_translation("invalid 4k", 39'h6044, 1'b0, 3);
      // faults stay out of the TLB
      check_translation("invalid 4k again", 39'h6044, 1'b0, 3);
      check_translation("invalid root", 39'hc000_0000, 1'b0, 1);
      check_translation("store not writable", 39'h4008, 1'b1, 3);
      check_translation("load not dirty", 39'h5010, 1'b0, 3);
      check_translation("store not dirty", 39'h5010, 1'b1, 0);
      finish_test("faults", e);

      e = errors;
      check_translation("before flush", 39'h0123, 1'b0, 3);
      check_translation("hit before flush", 39'h0123, 1'b0, 0);
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      check_translation("after flush", 39'h0123, 1'b0, 3);
      finish_test("flush", e);

      e = errors;
      for (int i = 0; i < 40; i++)
      begin
         kind = {$random(seed)} % 3;
         page = {$random(seed)} % 8;
         off = $random(seed);
         if (kind == 0)
            rva = {24'd0, page[2:0], off[11:0]};
         else if (kind == 1)
            rva = {9'd0, 9'd1, off[20:0]};
         else
            rva = {9'd1, off[29:0]};
         check_translation("random", rva, off[31], -1);
      end
      finish_test("random traffic", e);

      // handshake assertions in the bound checker
      if (dut_i.checker_i.failures != 0)
      begin
         $display("%0d handshake assertions failed", dut_i.checker_i.failures);
         errors += dut_i.checker_i.failures;
      end

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
hw/mmu_pkg.sv
hw/find_first_set.sv
hw/tlb.sv
hw/page_walker.sv
hw/xlate_front.sv
hw/mmu_top.sv
bench/mmu_checker.sv
bench/mmu_tb.sv

//--- hw/find_first_set.sv
`timescale 1ns/1ps
`default_nettype none

module find_first_set #(
   parameter int LG_N = 2
)
(
   input  wire [(1<<LG_N)-1:0] in,
   output logic [LG_N:0]       y
);

   localparam int N = 1 << LG_N;

   // scan downward so the lowest set bit is written last
   always_comb
   begin
      y = '0;
      for (int i = N - 1; i >= 0; i--)
      begin
         if (in[i])
         begin
            y = {1'b1, LG_N'(i)};
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

   localparam int VA_WIDTH = 39;
   localparam int PA_WIDTH = 40;
   // physical address minus the 12-bit page offset
   localparam int PPN_WIDTH = PA_WIDTH - 12;

   // page size codes, largest page first
   typedef enum logic [1:0] {
      PG_1G = 2'd0,
      PG_2M = 2'd1,
      PG_4K = 2'd2
   } pgsize_t;

   // leaf entry, R or W set
   typedef struct packed {
      logic [9:0]  reserved;
      logic [43:0] ppn;
      logic [1:0]  rsw;
      logic        d;
      logic        a;
      logic        g;
      logic        u;
      logic        x;
      logic        w;
      logic        r;
      logic        v;
   } pte_leaf_t;

   // pointer to the next table level
   typedef struct packed {
      logic [9:0]  reserved;
      logic [43:0] ppn;
      logic [8:0]  flags;
      logic        v;
   } pte_ptr_t;

   typedef union packed {
      pte_leaf_t leaf;
      pte_ptr_t  ptr;
   } pte_u;

endpackage

`default_nettype wire

//--- hw/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top
   import mmu_pkg::*;
#(
   parameter int LG_N = 2
)
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  active,
   input  wire                  clear,
   input  wire [PPN_WIDTH-1:0]  root_ppn,
   input  wire                  req,
   input  wire [VA_WIDTH-1:0]   va,
   input  wire                  store,
   output logic                 ack,
   output logic [PA_WIDTH-1:0]  pa,
   output logic                 fault,
   output logic                 mem_req,
   output logic [PA_WIDTH-1:0]  mem_addr,
   input  wire                  mem_ack,
   input  wire [63:0]           mem_rdata
);

   logic [VA_WIDTH-1:0]  lookup_va;
   logic                 tlb_hit;
   logic [PA_WIDTH-1:0]  tlb_pa;
   logic                 tlb_dirty;
   logic                 tlb_readable;
   logic                 tlb_writable;
   logic                 walk_req;
   logic                 walk_ack;
   logic                 walk_fault;
   logic [PPN_WIDTH-1:0] walk_ppn;
   pgsize_t              walk_size;
   logic                 walk_dirty;
   logic                 walk_readable;
   logic                 walk_writable;
   logic                 replace;

   xlate_front front_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .active       (active),
      .req          (req),
      .va           (va),
      .store        (store),
      .ack          (ack),
      .pa           (pa),
      .fault        (fault),
      .lookup_va    (lookup_va),
      .tlb_hit      (tlb_hit),
      .tlb_pa       (tlb_pa),
      .tlb_dirty    (tlb_dirty),
      .tlb_readable (tlb_readable),
      .tlb_writable (tlb_writable),
      .walk_req     (walk_req),
      .walk_ack     (walk_ack),
      .walk_fault   (walk_fault),
      .replace      (replace)
   );

   // refill data comes straight from the walker
   tlb #(.LG_N(LG_N)) tlb_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .active        (active),
      .clear         (clear),
      .va            (lookup_va),
      .hit           (tlb_hit),
      .pa            (tlb_pa),
      .dirty         (tlb_dirty),
      .readable      (tlb_readable),
      .writable      (tlb_writable),
      .replace       (replace),
      .replace_va    (lookup_va),
      .fill_ppn      (walk_ppn),
      .fill_size     (walk_size),
      .fill_dirty    (walk_dirty),
      .fill_readable (walk_readable),
      .fill_writable (walk_writable)
   );

   page_walker walker_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .root_ppn      (root_ppn),
      .walk_req      (walk_req),
      .walk_va       (lookup_va),
      .walk_ack      (walk_ack),
      .walk_fault    (walk_fault),
      .walk_ppn      (walk_ppn),
      .walk_size     (walk_size),
      .walk_dirty    (walk_dirty),
      .walk_readable (walk_readable),
      .walk_writable (walk_writable),
      .mem_req       (mem_req),
      .mem_addr      (mem_addr),
      .mem_ack       (mem_ack),
      .mem_rdata     (mem_rdata)
   );

endmodule

`default_nettype wire

//--- hw/page_walker.sv
`timescale 1ns/1ps
`default_nettype none

module page_walker
   import mmu_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire [PPN_WIDTH-1:0]  root_ppn,
   input  wire                  walk_req,
   input  wire [VA_WIDTH-1:0]   walk_va,
   output logic                 walk_ack,
   output logic                 walk_fault,
   output logic [PPN_WIDTH-1:0] walk_ppn,
   output pgsize_t              walk_size,
   output logic                 walk_dirty,
   output logic                 walk_readable,
   output logic                 walk_writable,
   output logic                 mem_req,
   output logic [PA_WIDTH-1:0]  mem_addr,
   input  wire                  mem_ack,
   input  wire [63:0]           mem_rdata
);

   typedef enum logic [1:0] {W_IDLE, W_MEM, W_RELEASE, W_DONE} wstate_t;

   wstate_t              state;
   logic [1:0]           level;
   logic [PPN_WIDTH-1:0] table_ppn;
   pte_u                 pte;
   logic [8:0]           vpn;
   logic [PPN_WIDTH-1:0] leaf_ppn;
   logic                 is_leaf;
   logic                 misaligned;
   logic                 descend;

   always_comb
   begin
      case (level)
         2'd2:    vpn = walk_va[38:30];
         2'd1:    vpn = walk_va[29:21];
         default: vpn = walk_va[20:12];
      endcase
   end

   // 8-byte PTE inside the current table
   assign mem_addr = {table_ppn, vpn, 3'b000};

   assign leaf_ppn = pte.leaf.ppn[PPN_WIDTH-1:0];
   assign is_leaf  = pte.leaf.r | pte.leaf.w;
   assign descend  = pte.ptr.v && !is_leaf && (level != 2'd0);

   // superpage leaf must have its low ppn bits clear
   always_comb
   begin
      case (level)
         2'd2:    misaligned = |leaf_ppn[17:0];
         2'd1:    misaligned = |leaf_ppn[8:0];
         default: misaligned = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= W_IDLE;
         level    <= 2'd2;
         mem_req  <= 1'b0;
         walk_ack <= 1'b0;
      end
      else
      begin
         case (state)
            W_IDLE:
               if (walk_req)
               begin
                  level   <= 2'd2;
                  mem_req <= 1'b1;
                  state   <= W_MEM;
               end
            W_MEM:
               if (mem_ack)
               begin
                  mem_req <= 1'b0;
                  state   <= W_RELEASE;
               end
            // decode once the memory has dropped its ack
            W_RELEASE:
               if (!mem_ack)
               begin
                  if (descend)
                  begin
                     level   <= level - 2'd1;
                     mem_req <= 1'b1;
                     state   <= W_MEM;
                  end
                  else
                  begin
                     walk_ack <= 1'b1;
                     state    <= W_DONE;
                  end
               end
            default:
               if (!walk_req)
               begin
                  walk_ack <= 1'b0;
                  state    <= W_IDLE;
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == W_IDLE)
         table_ppn <= root_ppn;
      else if (state == W_RELEASE && !mem_ack && descend)
         table_ppn <= pte.ptr.ppn[PPN_WIDTH-1:0];
      if (state == W_MEM && mem_ack)
         pte <= mem_rdata;
      // the last level visited leaves its result here
      if (state == W_RELEASE && !mem_ack)
      begin
         walk_fault    <= !pte.leaf.v || (is_leaf ? misaligned : (level == 2'd0));
         walk_ppn      <= leaf_ppn;
         walk_size     <= pgsize_t'(2'd2 - level);
         walk_dirty    <= pte.leaf.d;
         walk_readable <= pte.leaf.r;
         walk_writable <= pte.leaf.w;
      end
   end

endmodule

`default_nettype wire

//--- hw/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb
   import mmu_pkg::*;
#(
   parameter int LG_N = 2
)
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  active,
   input  wire                  clear,
   input  wire [VA_WIDTH-1:0]   va,
   output logic                 hit,
   output logic [PA_WIDTH-1:0]  pa,
   output logic                 dirty,
   output logic                 readable,
   output logic                 writable,
   input  wire                  replace,
   input  wire [VA_WIDTH-1:0]   replace_va,
   input  wire [PPN_WIDTH-1:0]  fill_ppn,
   input  wire pgsize_t         fill_size,
   input  wire                  fill_dirty,
   input  wire                  fill_readable,
   input  wire                  fill_writable
);

   localparam int N = 1 << LG_N;
   localparam int TAG_W = VA_WIDTH - 12;

   logic [N-1:0]         valid;
   logic [N-1:0]         e_dirty;
   logic [N-1:0]         e_readable;
   logic [N-1:0]         e_writable;
   pgsize_t              e_size [N];
   logic [TAG_W-1:0]     e_tag [N];
   logic [PPN_WIDTH-1:0] e_ppn [N];

   logic [N-1:0]         hits;
   logic [LG_N:0]        ffs_y;
   logic [LG_N-1:0]      sel;
   logic [LG_N-1:0]      victim;
   logic [15:0]          lfsr;
   logic [PA_WIDTH-1:0]  pa_sel;

   // compare only the tag bits above the page offset of each entry
   always_comb
   begin
      for (int i = 0; i < N; i++)
      begin
         case (e_size[i])
            PG_1G:   hits[i] = valid[i] && (e_tag[i][TAG_W-1:18] == va[VA_WIDTH-1:30]);
            PG_2M:   hits[i] = valid[i] && (e_tag[i][TAG_W-1:9] == va[VA_WIDTH-1:21]);
            default: hits[i] = valid[i] && (e_tag[i] == va[VA_WIDTH-1:12]);
         endcase
      end
   end

   find_first_set #(.LG_N(LG_N)) ffs_i (
      .in (hits),
      .y  (ffs_y)
   );

   assign sel = ffs_y[LG_N-1:0];
   assign victim = lfsr[LG_N:1];

   // superpages keep 21 or 30 offset bits from va
   always_comb
   begin
      case (e_size[sel])
         PG_1G:   pa_sel = {e_ppn[sel][PPN_WIDTH-1:18], va[29:0]};
         PG_2M:   pa_sel = {e_ppn[sel][PPN_WIDTH-1:9], va[20:0]};
         default: pa_sel = {e_ppn[sel], va[11:0]};
      endcase
   end

   // maximal 16-bit LFSR, taps 16 14 13 11
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr <= 16'd1;
      else
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         valid <= '0;
      else if (clear)
         valid <= '0;
      else if (replace)
         valid[victim] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (replace)
      begin
         e_dirty[victim]    <= fill_dirty;
         e_readable[victim] <= fill_readable;
         e_writable[victim] <= fill_writable;
         e_size[victim]     <= fill_size;
         e_tag[victim]      <= replace_va[VA_WIDTH-1:12];
         e_ppn[victim]      <= fill_ppn;
      end
   end

   // bare mode always hits
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         hit <= 1'b0;
      else
         hit <= active ? ffs_y[LG_N] : 1'b1;
   end

   always_ff @(posedge clk)
   begin
      pa       <= active ? pa_sel : {{(PA_WIDTH-VA_WIDTH){1'b0}}, va};
      dirty    <= e_dirty[sel];
      readable <= e_readable[sel];
      writable <= e_writable[sel];
   end

endmodule

`default_nettype wire

//--- hw/xlate_front.sv
`timescale 1ns/1ps
`default_nettype none

module xlate_front
   import mmu_pkg::*;
(
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire                 active,
   input  wire                 req,
   input  wire [VA_WIDTH-1:0]  va,
   input  wire                 store,
   output logic                ack,
   output logic [PA_WIDTH-1:0] pa,
   output logic                fault,
   output logic [VA_WIDTH-1:0] lookup_va,
   input  wire                 tlb_hit,
   input  wire [PA_WIDTH-1:0]  tlb_pa,
   input  wire                 tlb_dirty,
   input  wire                 tlb_readable,
   input  wire                 tlb_writable,
   output logic                walk_req,
   input  wire                 walk_ack,
   input  wire                 walk_fault,
   output logic                replace
);

   typedef enum logic [2:0] {F_IDLE, F_LOOKUP, F_CHECK, F_WALK, F_REFILL, F_ACK} fstate_t;

   fstate_t             state;
   logic [VA_WIDTH-1:0] r_va;
   logic                r_store;
   logic                perm_fault;

   assign lookup_va = r_va;

   // stores need a writable, dirty page; loads need a readable one
   assign perm_fault = active && (r_store ? (!tlb_writable || !tlb_dirty) : !tlb_readable);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= F_IDLE;
         ack      <= 1'b0;
         walk_req <= 1'b0;
         replace  <= 1'b0;
      end
      else
      begin
         replace <= 1'b0;
         case (state)
            F_IDLE:
               if (req)
                  state <= F_LOOKUP;
            F_LOOKUP:
               state <= F_CHECK;
            F_CHECK:
               if (tlb_hit)
               begin
                  ack   <= 1'b1;
                  state <= F_ACK;
               end
               else
               begin
                  walk_req <= 1'b1;
                  state    <= F_WALK;
               end
            F_WALK:
               if (walk_ack)
               begin
                  walk_req <= 1'b0;
                  if (walk_fault)
                  begin
                     ack   <= 1'b1;
                     state <= F_ACK;
                  end
                  else
                  begin
                     replace <= 1'b1;
                     state   <= F_REFILL;
                  end
               end
            // entry is written by now, look up again
            F_REFILL:
               if (!walk_ack)
                  state <= F_LOOKUP;
            F_ACK:
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= F_IDLE;
               end
            default:
               state <= F_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == F_IDLE && req)
      begin
         r_va    <= va;
         r_store <= store;
      end
      if (state == F_CHECK && tlb_hit)
      begin
         pa    <= tlb_pa;
         fault <= perm_fault;
      end
      else if (state == F_WALK && walk_ack && walk_fault)
      begin
         pa    <= '0;
         fault <= 1'b1;
      end
   end

endmodule

`default_nettype wire
